// ==== logic/decode_pkg.sv ====
package decode_pkg;

    // Instruction field widths
    localparam int INSTR_W   = 32;
    localparam int REG_IDX_W = 4;  // Sixteen registers, RV32E style

    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [INSTR_W-1:0]   imm_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [6:0]           funct7_t;
    typedef logic [6:0]           opcode_t;

    // Base opcodes, low two bits always 11
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OPIMM,
        CLS_OP,
        CLS_INVALID
    } instr_class_e;

    // Write-back source select
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_IMM = 2'd1,
        WB_MEM = 2'd2,
        WB_NPC = 2'd3  // Link address
    } wb_src_e;

    // Next-PC select
    typedef enum logic [1:0] {
        PC_NPC    = 2'd0,
        PC_JALR   = 2'd1,  // rs1 + imm, bit 0 cleared
        PC_OFFSET = 2'd2,  // pc + imm
        PC_BRANCH = 2'd3   // pc + imm when taken
    } pc_sel_e;

    typedef struct packed {
        logic     en;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } rd_rf_t;

    typedef struct packed {
        logic    en;
        logic    is_branch;
        logic    alt;     // SUB / SRA / SRAI
        funct3_t funct3;
    } ex_alu_t;

    typedef struct packed {
        logic    en;
        logic    is_store;
        funct3_t funct3;  // Access size and sign
    } ma_mem_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
    } wb_rf_t;

    typedef struct packed {
        logic    alu_a_pc;
        logic    alu_b_imm;
        wb_src_e wb_src;
    } mux_sel_t;

endpackage

// ==== logic/opcode_class.sv ====
`timescale 1ns/100ps

module opcode_class
    import decode_pkg::*;
(
    input  opcode_t      opcode,
    output instr_class_e cls
);

    // Full 7-bit compare, so bad low bits land in the default arm
    always_comb begin
        case (opcode)
            OPC_LUI:    cls = CLS_LUI;
            OPC_AUIPC:  cls = CLS_AUIPC;
            OPC_JAL:    cls = CLS_JAL;
            OPC_JALR:   cls = CLS_JALR;
            OPC_BRANCH: cls = CLS_BRANCH;
            OPC_LOAD:   cls = CLS_LOAD;
            OPC_STORE:  cls = CLS_STORE;
            OPC_OPIMM:  cls = CLS_OPIMM;
            OPC_OP:     cls = CLS_OP;
            default:    cls = CLS_INVALID;  // FENCE, SYSTEM and the rest
        endcase
    end

    // Compressed encodings never reach a base class
    a_cls_low_bits: assert property (@(cls) (opcode[1:0] != 2'b11) |-> (cls == CLS_INVALID))
        else $error("opcode_class: opcode %b decoded as class %0d", opcode, cls);

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen
    import decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic [24:0]  instr_hi,  // instr[31:7]
    input  instr_class_e cls,
    output imm_t         imm
);

    instr_t w;      // Rebuilt word so bit numbers match the spec
    imm_t   imm_d;

    assign w = {instr_hi, 7'b0};

    always_comb begin
        case (cls)
            CLS_LUI,
            CLS_AUIPC: begin
                imm_d = {w[31:12], 12'b0};  // U
            end
            CLS_JAL: begin
                imm_d = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            CLS_BRANCH: begin
                imm_d = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            CLS_STORE: begin
                imm_d = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            default: begin
                // I format, also harmless for OP and invalid
                imm_d = {{20{w[31]}}, w[31:20]};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            imm <= '0;
        end else begin
            imm <= imm_d;
        end
    end

endmodule

// ==== logic/fault_check.sv ====
`timescale 1ns/100ps

module fault_check
    import decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  instr_class_e cls,
    input  funct3_t      funct3,
    input  funct7_t      funct7,
    input  logic [4:0]   rd,
    input  logic [4:0]   rs1,
    input  logic [4:0]   rs2,
    output logic         fault
);

    logic bad_class;
    logic bad_rs1;
    logic bad_rs2;
    logic bad_rd;
    logic bad_funct3;
    logic bad_funct7;
    logic f7_zero;
    logic f7_alt;

    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    assign bad_class = (cls == CLS_INVALID);

    // Only x0..x15 exist
    assign bad_rs1 = rs1[4] && !(cls inside {CLS_LUI, CLS_AUIPC, CLS_JAL});
    assign bad_rs2 = rs2[4] && (cls inside {CLS_OP, CLS_STORE, CLS_BRANCH});
    assign bad_rd  = rd[4] && !(cls inside {CLS_STORE, CLS_BRANCH});

    always_comb begin
        case (cls)
            CLS_JALR:   bad_funct3 = (funct3 != 3'd0);
            CLS_LOAD:   bad_funct3 = (funct3 inside {3'd3, 3'd6, 3'd7});
            CLS_STORE:  bad_funct3 = (funct3 >= 3'd3);
            CLS_BRANCH: bad_funct3 = (funct3 inside {3'd2, 3'd3});
            default:    bad_funct3 = 1'b0;
        endcase
    end

    always_comb begin
        case (cls)
            CLS_OP: begin
                // Alternate encoding only for SUB and SRA
                bad_funct7 = !(f7_zero || (f7_alt && (funct3 inside {3'd0, 3'd5})));
            end
            CLS_OPIMM: begin
                if (funct3 == 3'd1) begin
                    bad_funct7 = !f7_zero;          // SLLI
                end else if (funct3 == 3'd5) begin
                    bad_funct7 = !(f7_zero || f7_alt);  // SRLI / SRAI
                end else begin
                    bad_funct7 = 1'b0;              // Upper bits are immediate
                end
            end
            default: bad_funct7 = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fault <= 1'b0;
        end else begin
            fault <= bad_class | bad_rs1 | bad_rs2 | bad_rd | bad_funct3 | bad_funct7;
        end
    end

    a_fault_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(fault))
        else $error("fault_check: fault is unknown");

endmodule

// ==== logic/stage_microcode.sv ====
`timescale 1ns/100ps

module stage_microcode
    import decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  instr_class_e cls,
    input  funct3_t      funct3,
    input  logic         alt_bit,  // instr[30]
    input  reg_idx_t     rs1,
    input  reg_idx_t     rs2,
    input  reg_idx_t     rd,
    output rd_rf_t       rd_rf,
    output ex_alu_t      ex_alu,
    output ma_mem_t      ma_mem,
    output wb_rf_t       wb_rf,
    output pc_sel_e      pc_sel,
    output mux_sel_t     mux_sel
);

    rd_rf_t   rd_rf_d;
    ex_alu_t  ex_alu_d;
    ma_mem_t  ma_mem_d;
    wb_rf_t   wb_rf_d;
    pc_sel_e  pc_sel_d;
    mux_sel_t mux_sel_d;

    always_comb begin
        rd_rf_d.en  = !(cls inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_INVALID});
        rd_rf_d.rs1 = rs1;
        rd_rf_d.rs2 = rs2;

        ex_alu_d.en        = !(cls inside {CLS_LUI, CLS_JAL, CLS_INVALID});
        ex_alu_d.is_branch = (cls == CLS_BRANCH);
        ex_alu_d.alt       = alt_bit &&
                             (((cls == CLS_OP) && (funct3 inside {3'd0, 3'd5})) ||
                              ((cls == CLS_OPIMM) && (funct3 == 3'd5)));
        ex_alu_d.funct3    = (cls inside {CLS_OP, CLS_OPIMM, CLS_BRANCH}) ? funct3 : '0;

        ma_mem_d.en       = (cls inside {CLS_LOAD, CLS_STORE});
        ma_mem_d.is_store = (cls == CLS_STORE);
        ma_mem_d.funct3   = funct3;

        wb_rf_d.en = !(cls inside {CLS_STORE, CLS_BRANCH, CLS_INVALID});
        wb_rf_d.rd = rd;

        mux_sel_d.alu_a_pc  = (cls == CLS_AUIPC);
        mux_sel_d.alu_b_imm = !(cls inside {CLS_BRANCH, CLS_OP});

        // Defaults cover ALU results falling through to pc + 4
        pc_sel_d         = PC_NPC;
        mux_sel_d.wb_src = WB_ALU;
        case (cls)
            CLS_LUI:    mux_sel_d.wb_src = WB_IMM;
            CLS_LOAD:   mux_sel_d.wb_src = WB_MEM;
            CLS_BRANCH: pc_sel_d = PC_BRANCH;
            CLS_JAL: begin
                pc_sel_d         = PC_OFFSET;
                mux_sel_d.wb_src = WB_NPC;
            end
            CLS_JALR: begin
                pc_sel_d         = PC_JALR;
                mux_sel_d.wb_src = WB_NPC;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_rf   <= '0;
            ex_alu  <= '0;
            ma_mem  <= '0;
            wb_rf   <= '0;
            pc_sel  <= PC_NPC;
            mux_sel <= '0;
        end else begin
            rd_rf   <= rd_rf_d;
            ex_alu  <= ex_alu_d;
            ma_mem  <= ma_mem_d;
            wb_rf   <= wb_rf_d;
            pc_sel  <= pc_sel_d;
            mux_sel <= mux_sel_d;
        end
    end

    // Address generation goes through the ALU
    a_mem_needs_alu: assert property (@(posedge clk) disable iff (rst) ma_mem.en |-> ex_alu.en)
        else $error("stage_microcode: memory stage enabled without ALU stage");

endmodule

// ==== logic/rv32_decoder.sv ====
`timescale 1ns/100ps

module rv32_decoder
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  instr_t   instr,
    output imm_t     imm,
    output mux_sel_t mux_sel,
    output rd_rf_t   rd_rf,
    output ex_alu_t  ex_alu,
    output ma_mem_t  ma_mem,
    output wb_rf_t   wb_rf,
    output pc_sel_e  pc_sel,
    output logic     fault
);

    opcode_t      opcode;
    funct3_t      funct3;
    funct7_t      funct7;
    logic [4:0]   rd;
    logic [4:0]   rs1;
    logic [4:0]   rs2;
    instr_class_e cls;

    // Field split
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    opcode_class u_class (
        .opcode (opcode),
        .cls    (cls)
    );

    imm_gen u_imm (
        .clk      (clk),
        .rst      (rst),
        .instr_hi (instr[31:7]),
        .cls      (cls),
        .imm      (imm)
    );

    fault_check u_fault (
        .clk    (clk),
        .rst    (rst),
        .cls    (cls),
        .funct3 (funct3),
        .funct7 (funct7),
        .rd     (rd),
        .rs1    (rs1),
        .rs2    (rs2),
        .fault  (fault)
    );

    // Index bit 4 is only checked in u_fault
    stage_microcode u_micro (
        .clk     (clk),
        .rst     (rst),
        .cls     (cls),
        .funct3  (funct3),
        .alt_bit (instr[30]),
        .rs1     (rs1[3:0]),
        .rs2     (rs2[3:0]),
        .rd      (rd[3:0]),
        .rd_rf   (rd_rf),
        .ex_alu  (ex_alu),
        .ma_mem  (ma_mem),
        .wb_rf   (wb_rf),
        .pc_sel  (pc_sel),
        .mux_sel (mux_sel)
    );

endmodule

// ==== include/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Reference model of the decoder, one function per output group

function automatic instr_class_e model_class(instr_t i);
    case (i[6:0])
        OPC_LUI:    return CLS_LUI;
        OPC_AUIPC:  return CLS_AUIPC;
        OPC_JAL:    return CLS_JAL;
        OPC_JALR:   return CLS_JALR;
        OPC_BRANCH: return CLS_BRANCH;
        OPC_LOAD:   return CLS_LOAD;
        OPC_STORE:  return CLS_STORE;
        OPC_OPIMM:  return CLS_OPIMM;
        OPC_OP:     return CLS_OP;
        default:    return CLS_INVALID;
    endcase
endfunction

function automatic imm_t model_imm(instr_t i);
    case (model_class(i))
        CLS_LUI, CLS_AUIPC: return {i[31:12], 12'b0};
        CLS_JAL:    return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        CLS_BRANCH: return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        CLS_STORE:  return {{20{i[31]}}, i[31:25], i[11:7]};
        default:    return {{20{i[31]}}, i[31:20]};
    endcase
endfunction

function automatic logic model_fault(instr_t i);
    instr_class_e c;
    logic [2:0]   f3;
    logic [6:0]   f7;
    logic         bad;
    c   = model_class(i);
    f3  = i[14:12];
    f7  = i[31:25];
    bad = (c == CLS_INVALID);
    bad |= i[19] && !(c inside {CLS_LUI, CLS_AUIPC, CLS_JAL});
    bad |= i[24] && (c inside {CLS_OP, CLS_STORE, CLS_BRANCH});
    bad |= i[11] && !(c inside {CLS_STORE, CLS_BRANCH});
    bad |= (c == CLS_JALR) && (f3 != 3'd0);
    bad |= (c == CLS_LOAD) && (f3 inside {3'd3, 3'd6, 3'd7});
    bad |= (c == CLS_STORE) && (f3 >= 3'd3);
    bad |= (c == CLS_BRANCH) && (f3 inside {3'd2, 3'd3});
    bad |= (c == CLS_OP) &&
           !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 inside {3'd0, 3'd5})));
    bad |= (c == CLS_OPIMM) && (f3 == 3'd1) && (f7 != 7'h00);
    bad |= (c == CLS_OPIMM) && (f3 == 3'd5) && !(f7 inside {7'h00, 7'h20});
    return bad;
endfunction

function automatic rd_rf_t model_rd_rf(instr_t i);
    return '{en:  !(model_class(i) inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_INVALID}),
             rs1: i[18:15],
             rs2: i[23:20]};
endfunction

function automatic ex_alu_t model_ex_alu(instr_t i);
    instr_class_e c;
    ex_alu_t      e;
    c           = model_class(i);
    e.en        = !(c inside {CLS_LUI, CLS_JAL, CLS_INVALID});
    e.is_branch = (c == CLS_BRANCH);
    e.alt       = i[30] && (((c == CLS_OP) && (i[14:12] inside {3'd0, 3'd5})) ||
                            ((c == CLS_OPIMM) && (i[14:12] == 3'd5)));
    e.funct3    = (c inside {CLS_OP, CLS_OPIMM, CLS_BRANCH}) ? i[14:12] : 3'd0;
    return e;
endfunction

function automatic ma_mem_t model_ma_mem(instr_t i);
    return '{en:       model_class(i) inside {CLS_LOAD, CLS_STORE},
             is_store: model_class(i) == CLS_STORE,
             funct3:   i[14:12]};
endfunction

function automatic wb_rf_t model_wb_rf(instr_t i);
    return '{en: !(model_class(i) inside {CLS_STORE, CLS_BRANCH, CLS_INVALID}),
             rd: i[10:7]};
endfunction

function automatic pc_sel_e model_pc_sel(instr_t i);
    case (model_class(i))
        CLS_JAL:    return PC_OFFSET;
        CLS_JALR:   return PC_JALR;
        CLS_BRANCH: return PC_BRANCH;
        default:    return PC_NPC;
    endcase
endfunction

function automatic mux_sel_t model_mux_sel(instr_t i);
    instr_class_e c;
    mux_sel_t     m;
    c           = model_class(i);
    m.alu_a_pc  = (c == CLS_AUIPC);
    m.alu_b_imm = !(c inside {CLS_BRANCH, CLS_OP});
    case (c)
        CLS_LUI:           m.wb_src = WB_IMM;
        CLS_LOAD:          m.wb_src = WB_MEM;
        CLS_JAL, CLS_JALR: m.wb_src = WB_NPC;
        default:           m.wb_src = WB_ALU;
    endcase
    return m;
endfunction

`endif

// ==== tb/tb_rv32_decoder.sv ====
`timescale 1ns/100ps

module tb_rv32_decoder
    import decode_pkg::*;
();

    `include "decode_model.svh"

    localparam int NUM_TESTS    = 4000;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_NS  = (NUM_TESTS + RESET_CYCLES) * 10 + 1000;

    logic     clk = 1'b0;
    logic     rst;
    instr_t   instr;
    imm_t     imm;
    mux_sel_t mux_sel;
    rd_rf_t   rd_rf;
    ex_alu_t  ex_alu;
    ma_mem_t  ma_mem;
    wb_rf_t   wb_rf;
    pc_sel_e  pc_sel;
    logic     fault;

    logic   applied;        // instr holds a test word
    instr_t sampled;        // Word the DUT took at the last edge
    logic   sampled_valid;
    integer seed;
    int     checks;
    int     errors;
    int     clean_count;    // Non-faulting words seen

    rv32_decoder u_dut (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .imm     (imm),
        .mux_sel (mux_sel),
        .rd_rf   (rd_rf),
        .ex_alu  (ex_alu),
        .ma_mem  (ma_mem),
        .wb_rf   (wb_rf),
        .pc_sel  (pc_sel),
        .fault   (fault)
    );

    always #5 clk = ~clk;

    function automatic opcode_t valid_opcode(int unsigned k);
        case (k)
            0:       return OPC_LUI;
            1:       return OPC_AUIPC;
            2:       return OPC_JAL;
            3:       return OPC_JALR;
            4:       return OPC_BRANCH;
            5:       return OPC_LOAD;
            6:       return OPC_STORE;
            7:       return OPC_OPIMM;
            default: return OPC_OP;
        endcase
    endfunction

    // Half the words get a legal opcode, the rest stay fully random
    function automatic instr_t random_instr();
        instr_t      word;
        logic [31:0] pick;
        word = $random(seed);
        pick = $random(seed);
        if (pick[0]) begin
            word[6:0] = valid_opcode(pick[31:4] % 9);
            if (pick[1]) begin
                // Indices in x0..x15 and a legal funct7, so SUB / SRA / SRAI show up
                word[11]    = 1'b0;
                word[19]    = 1'b0;
                word[24]    = 1'b0;
                word[31:25] = pick[2] ? 7'h20 : 7'h00;
            end
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        assert (act_v === exp_v)
        else begin
            errors++;
            $display("[ERROR] t=%0t %s expected %0h got %0h", $time, name, exp_v, act_v);
        end
    endtask

    // Scoreboard, mirrors the word the DUT registers on this edge
    always @(posedge clk) begin
        sampled       <= instr;
        sampled_valid <= applied;
    end

    always @(negedge clk) begin
        if (sampled_valid) begin
            check_value("fault", 32'(model_fault(sampled)), 32'(fault));
            if (!model_fault(sampled)) begin
                clean_count++;
                check_value("imm", model_imm(sampled), imm);
                check_value("rd_rf", 32'(model_rd_rf(sampled)), 32'(rd_rf));
                check_value("ex_alu", 32'(model_ex_alu(sampled)), 32'(ex_alu));
                check_value("ma_mem", 32'(model_ma_mem(sampled)), 32'(ma_mem));
                check_value("wb_rf", 32'(model_wb_rf(sampled)), 32'(wb_rf));
                check_value("pc_sel", 32'(model_pc_sel(sampled)), 32'(pc_sel));
                check_value("mux_sel", 32'(model_mux_sel(sampled)), 32'(mux_sel));
            end
        end else begin
            // Reset state until the first word comes through
            check_value("enables", 32'b0,
                        32'({rd_rf.en, ex_alu.en, ma_mem.en, wb_rf.en}));
            check_value("fault", 32'b0, 32'(fault));
            check_value("pc_sel", 32'(PC_NPC), 32'(pc_sel));
            check_value("imm", 32'b0, imm);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        instr         = '0;
        applied       = 1'b0;
        sampled       = '0;
        sampled_valid = 1'b0;
        seed          = 32'h0166_874d;
        checks        = 0;
        errors        = 0;
        clean_count   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_TESTS; n++) begin
            instr   <= random_instr();  // New word every cycle
            applied <= 1'b1;
            @(posedge clk);
        end
        applied <= 1'b0;
        @(negedge clk);
        #1;  // Let the last check run
        $display("Summary: %0d words, %0d non-faulting, %0d checks, %0d errors",
                 NUM_TESTS, clean_count, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
logic/decode_pkg.sv
logic/opcode_class.sv
logic/imm_gen.sv
logic/fault_check.sv
logic/stage_microcode.sv
logic/rv32_decoder.sv
tb/tb_rv32_decoder.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_rv32_decoder
FILELIST ?= all.f
OBJ_DIR  ?= obj_dir
PASS_MSG := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
